/* logic/scariv_conf_pkg.sv */
// Sizes and widths of the dispatch-to-writeback slice
// Imported by scariv_pkg and by any module that sizes ports or arrays
`default_nettype none

package scariv_conf_pkg;

  // Dispatch group
  localparam int DISP_SIZE = 2;

  // Datapath widths
  localparam int XLEN_W   = 32;
  localparam int FLEN_W   = 64;
  localparam int RNID_W   = 5;
  localparam int REG_NUM  = 1 << RNID_W;
  localparam int CMT_ID_W = 6;

  // Lanes, also the index of each lane's done report
  localparam int LANE_NUM = 2;
  localparam int ALU_LANE = 0;
  localparam int FPU_LANE = 1;

  // Register file ports, the last read port of each file is for the testbench
  localparam int INT_RD_PORT_NUM = 4;
  localparam int FP_RD_PORT_NUM  = 2;
  localparam int INT_WR_PORT_NUM = 2;
  localparam int FP_WR_PORT_NUM  = 1;

endpackage

`default_nettype wire

/* logic/scariv_pkg.sv */
// Encodings and packed structs shared by the slice
// Covers dispatch slots, lane results, register writes and done reports
`default_nettype none

package scariv_pkg;

  import scariv_conf_pkg::*;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    CAT_ARITH,
    CAT_FPU_MV,
    CAT_OTHER
  } inst_cat_t;

  typedef enum logic [2:0] {
    ADD,
    ADDI,
    SUB,
    AND,
    OR,
    XOR,
    FMV_W_X,
    FMV_X_W
  } op_t;

  typedef enum logic {
    GPR,
    FPR
  } reg_t;

  typedef logic [RNID_W-1:0]   rnid_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [XLEN_W-1:0]   int_data_t;
  typedef logic [FLEN_W-1:0]   fp_data_t;

  // ----------------------------------------
  // Dispatch
  // ----------------------------------------
  typedef struct packed {
    logic      valid;
    logic      illegal;
    inst_cat_t cat;
    op_t       op;
    reg_t      rd_type;
    rnid_t     rd_rnid;
    rnid_t     rs1_rnid;
    rnid_t     rs2_rnid;
    int_data_t imm;
    cmt_id_t   cmt_id;
  } disp_inst_t;

  typedef disp_inst_t [DISP_SIZE-1:0] disp_grp_t;

  // ----------------------------------------
  // Results and writeback
  // ----------------------------------------
  // Lane result, integer data sits in the low XLEN_W bits
  typedef struct packed {
    logic     valid;
    reg_t     rd_type;
    rnid_t    rd_rnid;
    fp_data_t rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic      valid;
    rnid_t     rnid;
    int_data_t data;
  } int_regwr_t;

  typedef struct packed {
    logic     valid;
    rnid_t    rnid;
    fp_data_t data;
  } fp_regwr_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
  } done_rpt_t;

endpackage

`default_nettype wire

/* logic/scariv_disp_steer.sv */
// Dispatch steering, combinational
// Picks for each lane the first usable slot of that lane's category
`timescale 1ns/1ns
`default_nettype none

module scariv_disp_steer (
  input  logic                   i_disp_valid,
  input  scariv_pkg::disp_grp_t  i_disp_grp,
  output scariv_pkg::disp_inst_t o_alu_issue,
  output scariv_pkg::disp_inst_t o_fpu_issue
);

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  // Slot may issue at all
  logic [DISP_SIZE-1:0] w_slot_ok;

  // Lowest matching slot wins, scan runs from the top so it overwrites last
  function automatic disp_inst_t pick_slot(input disp_grp_t grp,
                                           input logic [DISP_SIZE-1:0] ok,
                                           input inst_cat_t cat);
    disp_inst_t sel;
    sel = '0;
    for (int d = DISP_SIZE - 1; d >= 0; d--) begin
      if (ok[d] && (grp[d].cat == cat)) begin
        sel = grp[d];
      end
    end
    return sel;
  endfunction

  generate
    for (genvar d_idx = 0; d_idx < DISP_SIZE; d_idx++) begin : g_slot_ok
      assign w_slot_ok[d_idx] = i_disp_valid &
                                i_disp_grp[d_idx].valid &
                                !i_disp_grp[d_idx].illegal;
    end
  endgenerate

  // CAT_OTHER never matches, so those slots drop here
  assign o_alu_issue = pick_slot(i_disp_grp, w_slot_ok, CAT_ARITH);
  assign o_fpu_issue = pick_slot(i_disp_grp, w_slot_ok, CAT_FPU_MV);

endmodule

`default_nettype wire

/* logic/scariv_alu_lane.sv */
// Integer ALU lane, three stages
// ex1 reads the GPR file, ex2 computes, ex3 holds the result for writeback
`timescale 1ns/1ns
`default_nettype none

module scariv_alu_lane (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  scariv_pkg::disp_inst_t i_issue,
  output scariv_pkg::rnid_t     o_rs1_rnid,
  output scariv_pkg::rnid_t     o_rs2_rnid,
  input  scariv_pkg::int_data_t i_rs1_data,
  input  scariv_pkg::int_data_t i_rs2_data,
  output scariv_pkg::phy_wr_t   o_ex3_phy_wr,
  output scariv_pkg::cmt_id_t   o_cmt_id
);

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  disp_inst_t r_ex1_issue;
  logic       r_ex2_valid;
  op_t        r_ex2_op;
  rnid_t      r_ex2_rd_rnid;
  cmt_id_t    r_ex2_cmt_id;
  int_data_t  r_ex2_rs1_data;
  int_data_t  r_ex2_rs2_data;
  int_data_t  w_ex2_result;

  // ex1
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ex1_issue.valid <= 1'b0;
    end else begin
      r_ex1_issue <= i_issue;
    end
  end

  assign o_rs1_rnid = r_ex1_issue.rs1_rnid;
  assign o_rs2_rnid = r_ex1_issue.rs2_rnid;

  // ex2, imm replaces rs2 for ADDI
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex2_valid <= r_ex1_issue.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_op       <= r_ex1_issue.op;
    r_ex2_rd_rnid  <= r_ex1_issue.rd_rnid;
    r_ex2_cmt_id   <= r_ex1_issue.cmt_id;
    r_ex2_rs1_data <= i_rs1_data;
    r_ex2_rs2_data <= (r_ex1_issue.op == ADDI) ? r_ex1_issue.imm : i_rs2_data;
  end

  always_comb begin
    case (r_ex2_op)
      SUB:     w_ex2_result = r_ex2_rs1_data - r_ex2_rs2_data;
      AND:     w_ex2_result = r_ex2_rs1_data & r_ex2_rs2_data;
      OR:      w_ex2_result = r_ex2_rs1_data | r_ex2_rs2_data;
      XOR:     w_ex2_result = r_ex2_rs1_data ^ r_ex2_rs2_data;
      default: w_ex2_result = r_ex2_rs1_data + r_ex2_rs2_data;
    endcase
  end

  // ex3
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ex3_phy_wr.valid <= 1'b0;
    end else begin
      o_ex3_phy_wr.valid   <= r_ex2_valid;
      o_ex3_phy_wr.rd_type <= GPR;
      o_ex3_phy_wr.rd_rnid <= r_ex2_rd_rnid;
      o_ex3_phy_wr.rd_data <= {{(FLEN_W - XLEN_W){1'b0}}, w_ex2_result};
      o_cmt_id             <= r_ex2_cmt_id;
    end
  end

endmodule

`default_nettype wire

/* logic/scariv_fpu_mv_lane.sv */
// FP move lane, three stages
// FMV_W_X NaN-boxes a GPR into an FPR, FMV_X_W moves an FPR low word to a GPR
`timescale 1ns/1ns
`default_nettype none

module scariv_fpu_mv_lane (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  scariv_pkg::disp_inst_t i_issue,
  output scariv_pkg::rnid_t      o_int_rs1_rnid,
  input  scariv_pkg::int_data_t  i_int_rs1_data,
  output scariv_pkg::rnid_t      o_fp_rs1_rnid,
  input  scariv_pkg::fp_data_t   i_fp_rs1_data,
  output scariv_pkg::phy_wr_t    o_ex3_phy_wr,
  output scariv_pkg::cmt_id_t    o_cmt_id
);

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  disp_inst_t r_ex1_issue;
  logic       r_ex2_valid;
  op_t        r_ex2_op;
  reg_t       r_ex2_rd_type;
  rnid_t      r_ex2_rd_rnid;
  cmt_id_t    r_ex2_cmt_id;
  int_data_t  r_ex2_src;
  fp_data_t   w_ex2_data;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ex1_issue.valid <= 1'b0;
    end else begin
      r_ex1_issue <= i_issue;
    end
  end

  // Both files see the same rs1, op picks which one is used
  assign o_int_rs1_rnid = r_ex1_issue.rs1_rnid;
  assign o_fp_rs1_rnid  = r_ex1_issue.rs1_rnid;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex2_valid <= r_ex1_issue.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_op      <= r_ex1_issue.op;
    r_ex2_rd_type <= r_ex1_issue.rd_type;
    r_ex2_rd_rnid <= r_ex1_issue.rd_rnid;
    r_ex2_cmt_id  <= r_ex1_issue.cmt_id;
    r_ex2_src     <= (r_ex1_issue.op == FMV_W_X) ? i_int_rs1_data :
                                                   i_fp_rs1_data[XLEN_W-1:0];
  end

  // Upper word all ones marks a boxed single
  assign w_ex2_data = (r_ex2_op == FMV_W_X) ? {{(FLEN_W - XLEN_W){1'b1}}, r_ex2_src} :
                                             {{(FLEN_W - XLEN_W){1'b0}}, r_ex2_src};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ex3_phy_wr.valid <= 1'b0;
    end else begin
      o_ex3_phy_wr.valid   <= r_ex2_valid;
      o_ex3_phy_wr.rd_type <= r_ex2_rd_type;
      o_ex3_phy_wr.rd_rnid <= r_ex2_rd_rnid;
      o_ex3_phy_wr.rd_data <= w_ex2_data;
      o_cmt_id             <= r_ex2_cmt_id;
    end
  end

endmodule

`default_nettype wire

/* logic/scariv_phy_registers.sv */
// Physical register file, 32 entries of DATA_T
// Serves both the GPR and the FPR file; reads are combinational
`timescale 1ns/1ns
`default_nettype none

module scariv_phy_registers #(
  parameter type DATA_T       = scariv_pkg::int_data_t,
  parameter int  RD_PORT_SIZE = 1,
  parameter int  WR_PORT_SIZE = 1
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_wr_valid[WR_PORT_SIZE],
  input  scariv_pkg::rnid_t i_wr_rnid [WR_PORT_SIZE],
  input  DATA_T             i_wr_data [WR_PORT_SIZE],
  input  scariv_pkg::rnid_t i_rd_rnid [RD_PORT_SIZE],
  output DATA_T             o_rd_data [RD_PORT_SIZE]
);

  import scariv_conf_pkg::*;

  DATA_T r_regs[REG_NUM];

  // Later ports overwrite earlier ones on a same-index write
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int r = 0; r < REG_NUM; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < WR_PORT_SIZE; w++) begin
        if (i_wr_valid[w]) begin
          r_regs[i_wr_rnid[w]] <= i_wr_data[w];
        end
      end
    end
  end

  // No bypass, a write shows up the cycle after its edge
  generate
    for (genvar p_idx = 0; p_idx < RD_PORT_SIZE; p_idx++) begin : g_rd
      assign o_rd_data[p_idx] = r_regs[i_rd_rnid[p_idx]];
    end
  endgenerate

endmodule

`default_nettype wire

/* logic/scariv_wb_merge.sv */
// Writeback merger
// Routes lane results to GPR/FPR write ports by rd_type and registers one
// done report per lane in the same cycle as the writes
`timescale 1ns/1ns
`default_nettype none

module scariv_wb_merge (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  scariv_pkg::phy_wr_t    i_alu_wr,
  input  scariv_pkg::phy_wr_t    i_fpu_wr,
  input  scariv_pkg::cmt_id_t    i_alu_cmt_id,
  input  scariv_pkg::cmt_id_t    i_fpu_cmt_id,
  output scariv_pkg::int_regwr_t o_int_regwrite[scariv_conf_pkg::INT_WR_PORT_NUM],
  output scariv_pkg::fp_regwr_t  o_fp_regwrite [scariv_conf_pkg::FP_WR_PORT_NUM],
  output scariv_pkg::done_rpt_t  o_done_rpt    [scariv_conf_pkg::LANE_NUM]
);

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  int_regwr_t w_int_next [INT_WR_PORT_NUM];
  fp_regwr_t  w_fp_next  [FP_WR_PORT_NUM];
  done_rpt_t  w_done_next[LANE_NUM];

  // ----------------------------------------
  // Routing
  // ----------------------------------------
  always_comb begin
    // ALU always targets the GPR file
    w_int_next[ALU_LANE].valid = i_alu_wr.valid;
    w_int_next[ALU_LANE].rnid  = i_alu_wr.rd_rnid;
    w_int_next[ALU_LANE].data  = i_alu_wr.rd_data[XLEN_W-1:0];

    w_int_next[FPU_LANE].valid = i_fpu_wr.valid & (i_fpu_wr.rd_type == GPR);
    w_int_next[FPU_LANE].rnid  = i_fpu_wr.rd_rnid;
    w_int_next[FPU_LANE].data  = i_fpu_wr.rd_data[XLEN_W-1:0];

    w_fp_next[0].valid = i_fpu_wr.valid & (i_fpu_wr.rd_type == FPR);
    w_fp_next[0].rnid  = i_fpu_wr.rd_rnid;
    w_fp_next[0].data  = i_fpu_wr.rd_data;

    w_done_next[ALU_LANE].valid  = i_alu_wr.valid;
    w_done_next[ALU_LANE].cmt_id = i_alu_cmt_id;
    w_done_next[FPU_LANE].valid  = i_fpu_wr.valid;
    w_done_next[FPU_LANE].cmt_id = i_fpu_cmt_id;
  end

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int p = 0; p < INT_WR_PORT_NUM; p++) begin
        o_int_regwrite[p].valid <= 1'b0;
      end
      for (int p = 0; p < FP_WR_PORT_NUM; p++) begin
        o_fp_regwrite[p].valid <= 1'b0;
      end
      for (int l = 0; l < LANE_NUM; l++) begin
        o_done_rpt[l].valid <= 1'b0;
      end
    end else begin
      o_int_regwrite <= w_int_next;
      o_fp_regwrite  <= w_fp_next;
      o_done_rpt     <= w_done_next;
    end
  end

endmodule

`default_nettype wire

/* logic/scariv_tile.sv */
// Top of the dispatch-to-writeback slice
// Steering, the ALU and FP move lanes, writeback merge and both register
// files; the last read port of each file is brought out for inspection
`timescale 1ns/1ns
`default_nettype none

module scariv_tile (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_disp_valid,
  input  scariv_pkg::disp_grp_t i_disp_grp,
  input  scariv_pkg::rnid_t     i_int_rd_rnid,
  output scariv_pkg::int_data_t o_int_rd_data,
  input  scariv_pkg::rnid_t     i_fp_rd_rnid,
  output scariv_pkg::fp_data_t  o_fp_rd_data,
  output scariv_pkg::done_rpt_t o_done_rpt[scariv_conf_pkg::LANE_NUM]
);

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  disp_inst_t w_alu_issue;
  disp_inst_t w_fpu_issue;
  phy_wr_t    w_alu_phy_wr;
  phy_wr_t    w_fpu_phy_wr;
  cmt_id_t    w_alu_cmt_id;
  cmt_id_t    w_fpu_cmt_id;

  // Int read ports: ALU rs1, ALU rs2, FPU int rs1, top level
  rnid_t      w_int_rd_rnid[INT_RD_PORT_NUM];
  int_data_t  w_int_rd_data[INT_RD_PORT_NUM];
  // FP read ports: FPU fp rs1, top level
  rnid_t      w_fp_rd_rnid [FP_RD_PORT_NUM];
  fp_data_t   w_fp_rd_data [FP_RD_PORT_NUM];

  int_regwr_t w_int_regwrite[INT_WR_PORT_NUM];
  fp_regwr_t  w_fp_regwrite [FP_WR_PORT_NUM];
  logic       w_int_wr_valid[INT_WR_PORT_NUM];
  rnid_t      w_int_wr_rnid [INT_WR_PORT_NUM];
  int_data_t  w_int_wr_data [INT_WR_PORT_NUM];
  logic       w_fp_wr_valid [FP_WR_PORT_NUM];
  rnid_t      w_fp_wr_rnid  [FP_WR_PORT_NUM];
  fp_data_t   w_fp_wr_data  [FP_WR_PORT_NUM];

  assign w_int_rd_rnid[INT_RD_PORT_NUM-1] = i_int_rd_rnid;
  assign o_int_rd_data = w_int_rd_data[INT_RD_PORT_NUM-1];
  assign w_fp_rd_rnid[FP_RD_PORT_NUM-1] = i_fp_rd_rnid;
  assign o_fp_rd_data = w_fp_rd_data[FP_RD_PORT_NUM-1];

  generate
    for (genvar p_idx = 0; p_idx < INT_WR_PORT_NUM; p_idx++) begin : g_int_wr
      assign w_int_wr_valid[p_idx] = w_int_regwrite[p_idx].valid;
      assign w_int_wr_rnid[p_idx]  = w_int_regwrite[p_idx].rnid;
      assign w_int_wr_data[p_idx]  = w_int_regwrite[p_idx].data;
    end
    for (genvar p_idx = 0; p_idx < FP_WR_PORT_NUM; p_idx++) begin : g_fp_wr
      assign w_fp_wr_valid[p_idx] = w_fp_regwrite[p_idx].valid;
      assign w_fp_wr_rnid[p_idx]  = w_fp_regwrite[p_idx].rnid;
      assign w_fp_wr_data[p_idx]  = w_fp_regwrite[p_idx].data;
    end
  endgenerate

  scariv_disp_steer u_disp_steer (
    .i_disp_valid (i_disp_valid),
    .i_disp_grp   (i_disp_grp),
    .o_alu_issue  (w_alu_issue),
    .o_fpu_issue  (w_fpu_issue)
  );

  scariv_alu_lane u_alu_lane (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_issue      (w_alu_issue),
    .o_rs1_rnid   (w_int_rd_rnid[0]),
    .o_rs2_rnid   (w_int_rd_rnid[1]),
    .i_rs1_data   (w_int_rd_data[0]),
    .i_rs2_data   (w_int_rd_data[1]),
    .o_ex3_phy_wr (w_alu_phy_wr),
    .o_cmt_id     (w_alu_cmt_id)
  );

  scariv_fpu_mv_lane u_fpu_mv_lane (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_issue        (w_fpu_issue),
    .o_int_rs1_rnid (w_int_rd_rnid[2]),
    .i_int_rs1_data (w_int_rd_data[2]),
    .o_fp_rs1_rnid  (w_fp_rd_rnid[0]),
    .i_fp_rs1_data  (w_fp_rd_data[0]),
    .o_ex3_phy_wr   (w_fpu_phy_wr),
    .o_cmt_id       (w_fpu_cmt_id)
  );

  scariv_wb_merge u_wb_merge (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_alu_wr       (w_alu_phy_wr),
    .i_fpu_wr       (w_fpu_phy_wr),
    .i_alu_cmt_id   (w_alu_cmt_id),
    .i_fpu_cmt_id   (w_fpu_cmt_id),
    .o_int_regwrite (w_int_regwrite),
    .o_fp_regwrite  (w_fp_regwrite),
    .o_done_rpt     (o_done_rpt)
  );

  scariv_phy_registers #(
    .DATA_T       (int_data_t),
    .RD_PORT_SIZE (INT_RD_PORT_NUM),
    .WR_PORT_SIZE (INT_WR_PORT_NUM)
  ) u_int_phy_registers (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr_valid (w_int_wr_valid),
    .i_wr_rnid  (w_int_wr_rnid),
    .i_wr_data  (w_int_wr_data),
    .i_rd_rnid  (w_int_rd_rnid),
    .o_rd_data  (w_int_rd_data)
  );

  scariv_phy_registers #(
    .DATA_T       (fp_data_t),
    .RD_PORT_SIZE (FP_RD_PORT_NUM),
    .WR_PORT_SIZE (FP_WR_PORT_NUM)
  ) u_fp_phy_registers (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr_valid (w_fp_wr_valid),
    .i_wr_rnid  (w_fp_wr_rnid),
    .i_wr_data  (w_fp_wr_data),
    .i_rd_rnid  (w_fp_rd_rnid),
    .o_rd_data  (w_fp_rd_data)
  );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
// Clock and reset source for the tile testbench
// 100 ns clock, reset held high over the first three rising edges
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD = 50,
  parameter int RST_CYCLES  = 3
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* sim/scariv_wb_merge_checker.sv */
// Concurrent checks on the writeback merger, attached to it with bind
// Done reports follow lane results by one cycle and the FP port only
// ever carries FPU moves
`timescale 1ns/1ns
`default_nettype none

module scariv_wb_merge_checker (
  input logic                  i_clk,
  input logic                  i_rst,
  input scariv_pkg::phy_wr_t   i_alu_wr,
  input scariv_pkg::phy_wr_t   i_fpu_wr,
  input scariv_pkg::cmt_id_t   i_alu_cmt_id,
  input scariv_pkg::cmt_id_t   i_fpu_cmt_id,
  input scariv_pkg::fp_regwr_t i_fp_regwrite[scariv_conf_pkg::FP_WR_PORT_NUM],
  input scariv_pkg::done_rpt_t i_done_rpt[scariv_conf_pkg::LANE_NUM]
);

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  // ----------------------------------------
  // Done reports
  // ----------------------------------------
  a_alu_done: assert property (@(posedge i_clk) disable iff (i_rst)
    i_done_rpt[ALU_LANE].valid == $past(i_alu_wr.valid))
    else $error("ALU done report valid does not match the ALU result one cycle before");

  a_fpu_done: assert property (@(posedge i_clk) disable iff (i_rst)
    i_done_rpt[FPU_LANE].valid == $past(i_fpu_wr.valid))
    else $error("FPU done report valid does not match the FPU result one cycle before");

  a_alu_cmt: assert property (@(posedge i_clk) disable iff (i_rst)
    i_alu_wr.valid |=> i_done_rpt[ALU_LANE].cmt_id == $past(i_alu_cmt_id))
    else $error("ALU done report carries the wrong cmt_id");

  a_fpu_cmt: assert property (@(posedge i_clk) disable iff (i_rst)
    i_fpu_wr.valid |=> i_done_rpt[FPU_LANE].cmt_id == $past(i_fpu_cmt_id))
    else $error("FPU done report carries the wrong cmt_id");

  // ----------------------------------------
  // FP write port source
  // ----------------------------------------
  a_fp_port_src: assert property (@(posedge i_clk) disable iff (i_rst)
    i_fp_regwrite[0].valid |-> $past(i_fpu_wr.valid) && ($past(i_fpu_wr.rd_type) == FPR))
    else $error("FP write port fired without an FPU move to an FPR");

endmodule

`default_nettype wire

/* sim/tb_scariv_tile.sv */
// Testbench for the dispatch-to-writeback tile
// Reads dispatch groups and register checks from sim/tile_stim.txt, keeps
// a model of both register files and checks done reports and readback
`timescale 1ns/1ns
`default_nettype none

module tb_scariv_tile;

  import scariv_conf_pkg::*;
  import scariv_pkg::*;

  localparam int TIMEOUT_CYC = 100;
  localparam int NUM_FIELDS  = 21;

  typedef logic [31:0] field_t;

  // Expected done report and the cycle it must show up in
  typedef struct packed {
    int        due;
    int        src_line;
    logic      lane;
    done_rpt_t rpt;
  } exp_done_t;

  logic      clk;
  logic      rst;
  logic      r_disp_valid;
  disp_grp_t r_disp_grp;
  rnid_t     r_int_rd_rnid;
  rnid_t     r_fp_rd_rnid;
  int_data_t w_int_rd_data;
  fp_data_t  w_fp_rd_data;
  done_rpt_t w_done_rpt[LANE_NUM];

  int_data_t model_int[REG_NUM];
  fp_data_t  model_fp[REG_NUM];
  exp_done_t exp_q[$];
  int        cyc = 0;
  int        err_cnt = 0;
  logic      mon_on = 1'b0;

  tb_clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  scariv_tile i_scariv_tile (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_disp_valid  (r_disp_valid),
    .i_disp_grp    (r_disp_grp),
    .i_int_rd_rnid (r_int_rd_rnid),
    .o_int_rd_data (w_int_rd_data),
    .i_fp_rd_rnid  (r_fp_rd_rnid),
    .o_fp_rd_data  (w_fp_rd_data),
    .o_done_rpt    (w_done_rpt)
  );

  bind scariv_wb_merge scariv_wb_merge_checker u_wb_merge_checker (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_alu_wr      (i_alu_wr),
    .i_fpu_wr      (i_fpu_wr),
    .i_alu_cmt_id  (i_alu_cmt_id),
    .i_fpu_cmt_id  (i_fpu_cmt_id),
    .i_fp_regwrite (o_fp_regwrite),
    .i_done_rpt    (o_done_rpt)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------
  // Error handling and compare tasks
  // ----------------------------------------
  task automatic fail_run();
    err_cnt++;
    $display("Test failures found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic timeout(input string what);
    $display("Timeout while waiting for %s", what);
    fail_run();
  endtask

  task automatic check_done(input string name, input done_rpt_t exp, input done_rpt_t act);
    if (exp !== act) begin
      $display("Error: %s expected valid=%0b cmt_id=%h actual valid=%0b cmt_id=%h",
               name, exp.valid, exp.cmt_id, act.valid, act.cmt_id);
      fail_run();
    end
  endtask

  task automatic check_int(input string name, input int_data_t exp, input int_data_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_fp(input string name, input fp_data_t exp, input fp_data_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // First valid, legal slot of a category, as the steering picks it
  function automatic disp_inst_t first_of_cat(input disp_grp_t grp, input inst_cat_t cat);
    for (int s = 0; s < DISP_SIZE; s++) begin
      if (grp[s].valid && !grp[s].illegal && (grp[s].cat == cat)) begin
        return grp[s];
      end
    end
    return '0;
  endfunction

  function automatic int_data_t alu_value(input disp_inst_t inst);
    int_data_t a;
    int_data_t b;
    a = model_int[inst.rs1_rnid];
    b = (inst.op == ADDI) ? inst.imm : model_int[inst.rs2_rnid];
    case (inst.op)
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      default: return a + b;
    endcase
  endfunction

  function automatic disp_inst_t make_slot(input field_t fld[NUM_FIELDS], input int base);
    disp_inst_t s;
    s.valid    = fld[base][0];
    s.illegal  = fld[base+1][0];
    s.cat      = inst_cat_t'(fld[base+2][1:0]);
    s.op       = op_t'(fld[base+3][2:0]);
    s.rd_type  = reg_t'(fld[base+4][0]);
    s.rd_rnid  = fld[base+5][RNID_W-1:0];
    s.rs1_rnid = fld[base+6][RNID_W-1:0];
    s.rs2_rnid = fld[base+7][RNID_W-1:0];
    s.imm      = fld[base+8];
    s.cmt_id   = fld[base+9][CMT_ID_W-1:0];
    return s;
  endfunction

  // ----------------------------------------
  // Driving and reading
  // ----------------------------------------
  task automatic dispatch(input disp_grp_t grp, input int src_line,
                          output disp_inst_t alu, output disp_inst_t fpu);
    exp_done_t e;
    int_data_t alu_val;
    fp_data_t  fpu_val;
    @(posedge clk);
    r_disp_valid <= 1'b1;
    r_disp_grp   <= grp;
    alu = first_of_cat(grp, CAT_ARITH);
    fpu = first_of_cat(grp, CAT_FPU_MV);
    alu_val = alu_value(alu);
    if (fpu.op == FMV_W_X) begin
      fpu_val = {{(FLEN_W - XLEN_W){1'b1}}, model_int[fpu.rs1_rnid]};
    end else begin
      fpu_val = {{(FLEN_W - XLEN_W){1'b0}}, model_fp[fpu.rs1_rnid][XLEN_W-1:0]};
    end
    // Group is sampled one edge later, done follows three edges after that
    e.due      = cyc + 5;
    e.src_line = src_line;
    if (alu.valid) begin
      e.lane = 1'(ALU_LANE);
      e.rpt  = {1'b1, alu.cmt_id};
      exp_q.push_back(e);
      model_int[alu.rd_rnid] = alu_val;
    end
    if (fpu.valid) begin
      e.lane = 1'(FPU_LANE);
      e.rpt  = {1'b1, fpu.cmt_id};
      exp_q.push_back(e);
      if (fpu.rd_type == FPR) begin
        model_fp[fpu.rd_rnid] = fpu_val;
      end else begin
        model_int[fpu.rd_rnid] = fpu_val[XLEN_W-1:0];
      end
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    r_disp_valid <= 1'b0;
  endtask

  task automatic read_int(input string name, input rnid_t rnid, input int_data_t exp);
    @(posedge clk);
    r_disp_valid  <= 1'b0;
    r_int_rd_rnid <= rnid;
    @(negedge clk);
    check_int(name, exp, w_int_rd_data);
  endtask

  task automatic read_fp(input string name, input rnid_t rnid, input fp_data_t exp);
    @(posedge clk);
    r_disp_valid <= 1'b0;
    r_fp_rd_rnid <= rnid;
    @(negedge clk);
    check_fp(name, exp, w_fp_rd_data);
  endtask

  task automatic check_reset_state();
    for (int r = 0; r < REG_NUM; r++) begin
      @(posedge clk);
      r_int_rd_rnid <= rnid_t'(r);
      r_fp_rd_rnid  <= rnid_t'(r);
      @(negedge clk);
      check_int($sformatf("reset int r%0d", r), '0, w_int_rd_data);
      check_fp($sformatf("reset fp r%0d", r), '0, w_fp_rd_data);
    end
  endtask

  // Done monitor, one expected report per lane and cycle at most
  task automatic check_done_cycle();
    logic      exp_v[LANE_NUM];
    done_rpt_t exp_r[LANE_NUM];
    int        exp_line[LANE_NUM];
    for (int l = 0; l < LANE_NUM; l++) begin
      exp_v[l]    = 1'b0;
      exp_r[l]    = '0;
      exp_line[l] = 0;
    end
    while ((exp_q.size() != 0) && (exp_q[0].due == cyc)) begin
      exp_v[exp_q[0].lane]    = 1'b1;
      exp_r[exp_q[0].lane]    = exp_q[0].rpt;
      exp_line[exp_q[0].lane] = exp_q[0].src_line;
      void'(exp_q.pop_front());
    end
    for (int l = 0; l < LANE_NUM; l++) begin
      if (exp_v[l]) begin
        check_done($sformatf("line %0d done lane %0d", exp_line[l], l), exp_r[l], w_done_rpt[l]);
      end else if (w_done_rpt[l].valid !== 1'b0) begin
        $display("Unexpected done report on lane %0d at cycle %0d", l, cyc);
        fail_run();
      end
    end
  endtask

  always @(negedge clk) begin
    if (mon_on) begin
      check_done_cycle();
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    string      line;
    byte        tag;
    int         fd;
    int         cnt;
    int         lnum;
    int         gap;
    int         idle;
    int         wait_cyc;
    field_t     fld[NUM_FIELDS];
    logic [31:0] rn;
    logic [63:0] val;
    disp_grp_t  grp;
    disp_inst_t alu;
    disp_inst_t fpu;

    r_disp_valid  = 1'b0;
    r_disp_grp    = '0;
    r_int_rd_rnid = '0;
    r_fp_rd_rnid  = '0;
    lnum          = 0;
    void'($urandom(95));
    for (int r = 0; r < REG_NUM; r++) begin
      model_int[r] = '0;
      model_fp[r]  = '0;
    end

    wait_cyc = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        timeout("reset release");
      end
    end
    mon_on = 1'b1;
    check_reset_state();

    fd = $fopen("sim/tile_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sim/tile_stim.txt");
      fail_run();
    end

    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      lnum++;
      if ((cnt == 0) || (line.len() < 2) || (line.getc(0) == "#")) begin
        continue;
      end
      tag = line.getc(0);
      if (tag == "D") begin
        cnt = $sscanf(line,
          "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9],
          fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16], fld[17], fld[18],
          fld[19], fld[20]);
        if (cnt != NUM_FIELDS) begin
          $display("Malformed dispatch record on line %0d", lnum);
          fail_run();
        end
        grp[0] = make_slot(fld, 1);
        grp[1] = make_slot(fld, 11);
        dispatch(grp, lnum, alu, fpu);
        // Back-to-back groups skip the gap and the readback
        if (!fld[0][0]) begin
          gap  = 4 + $urandom % 4;
          idle = 0;
          repeat (4) begin
            idle_cycle();
            idle++;
          end
          if (alu.valid) begin
            read_int($sformatf("line %0d alu r%0d", lnum, alu.rd_rnid),
                     alu.rd_rnid, model_int[alu.rd_rnid]);
            idle++;
          end
          if (fpu.valid && (fpu.rd_type == FPR)) begin
            read_fp($sformatf("line %0d fpu f%0d", lnum, fpu.rd_rnid),
                    fpu.rd_rnid, model_fp[fpu.rd_rnid]);
            idle++;
          end else if (fpu.valid) begin
            read_int($sformatf("line %0d fpu r%0d", lnum, fpu.rd_rnid),
                     fpu.rd_rnid, model_int[fpu.rd_rnid]);
            idle++;
          end
          while (idle < gap) begin
            idle_cycle();
            idle++;
          end
        end
      end else if ((tag == "I") || (tag == "F")) begin
        cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h", rn, val);
        if (cnt != 2) begin
          $display("Malformed register record on line %0d", lnum);
          fail_run();
        end
        if (tag == "I") begin
          read_int($sformatf("line %0d int r%0d", lnum, rn), rn[RNID_W-1:0], val[XLEN_W-1:0]);
        end else begin
          read_fp($sformatf("line %0d fp f%0d", lnum, rn), rn[RNID_W-1:0], val);
        end
      end else begin
        $display("Unknown record type on line %0d", lnum);
        fail_run();
      end
    end
    $fclose(fd);

    wait_cyc = 0;
    while (exp_q.size() != 0) begin
      idle_cycle();
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        timeout("pending done reports");
      end
    end

    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tile_stim.txt */
# D b2b | slot0: v il cat op rdt rd rs1 rs2 imm cmt | slot1: same ten fields (all hex)
# I rnid value = expected GPR, F rnid value = expected FPR
# cat 0 arith 1 fpu_mv 2 other, op 0 add 1 addi 2 sub 3 and 4 or 5 xor 6 fmv_w_x 7 fmv_x_w
# ALU chain from r0
D 0 1 0 0 1 0 01 00 00 12345678 01 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 1 0 02 00 00 0F0F00FF 02 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 0 0 03 01 02 00000000 03 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 2 0 04 01 02 00000000 04 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 3 0 05 01 02 00000000 05 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 4 0 06 01 02 00000000 06 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 5 0 07 01 02 00000000 07 0 0 0 0 0 00 00 00 00000000 00
# FP moves, the first one steered from slot 1
D 0 0 0 0 0 0 00 00 00 00000000 00 1 0 1 6 1 01 01 00 00000000 08
D 0 1 0 1 7 0 08 01 00 00000000 09 0 0 0 0 0 00 00 00 00000000 00
# One instruction per lane in one group
D 0 1 0 1 6 1 02 03 00 00000000 0A 1 0 0 1 0 09 00 00 00000055 0B
# Illegal slot and CAT_OTHER slot
D 0 1 1 0 1 0 0A 00 00 0000DEAD 0C 1 0 2 1 0 0B 00 00 0000BEEF 0D
D 0 1 1 0 1 0 0A 00 00 0000DEAD 0E 1 0 0 1 0 0C 00 00 00000077 0F
# Back-to-back independent groups
D 1 1 0 0 1 0 0D 00 00 00000100 10 1 0 1 6 1 03 02 00 00000000 11
D 1 1 0 0 1 0 0E 00 00 00000200 12 1 0 1 7 0 0F 01 00 00000000 13
D 1 1 0 0 5 0 10 01 02 00000000 14 0 0 0 0 0 00 00 00 00000000 00
D 0 1 0 0 2 0 11 02 01 00000000 15 1 0 1 6 1 04 09 00 00000000 16
# Final register state
I 03 21435777
I 08 12345678
I 0A 00000000
I 0B 00000000
I 0C 00000077
I 0D 00000100
I 0E 00000200
I 0F 12345678
I 10 1D3B5687
I 11 FCDAAA87
F 01 FFFFFFFF12345678
F 02 FFFFFFFF21435777
F 03 FFFFFFFF0F0F00FF
F 04 FFFFFFFF00000055

/* flist.f */
logic/scariv_conf_pkg.sv
logic/scariv_pkg.sv
logic/scariv_disp_steer.sv
logic/scariv_alu_lane.sv
logic/scariv_fpu_mv_lane.sv
logic/scariv_phy_registers.sv
logic/scariv_wb_merge.sv
logic/scariv_tile.sv
sim/tb_clk_gen.sv
sim/scariv_wb_merge_checker.sv
sim/tb_scariv_tile.sv

/* Makefile */
SIM_TOOL  = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_scariv_tile
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
